/* audio_pkg.sv */
`default_nettype none

package audio_pkg;

	localparam int sample_bits = 16;
	localparam int addr_bits = 4;
	localparam int phase_bits = 24;
	localparam int frame_bits = 64;

	localparam logic [phase_bits-1:0] phase_limit = 24'h7fffff; // half of full scale.

	localparam int sclk_div_bits = 2;  // sclk toggles every 4 CLK.
	localparam int lrclk_div_bits = 8; // lrclk toggles every 256 CLK.

	// sample sits right after the leading zero bit of the slot.
	localparam int word_msb = frame_bits - 2;
	localparam int word_lsb = frame_bits - 1 - sample_bits;

	typedef enum logic [addr_bits-1:0] {
		reg_freq = 4'h0,
		reg_ampl = 4'h1
	} reg_addr_e;

	typedef struct packed {
		logic [sample_bits-1:0] freq;
		logic [sample_bits-1:0] ampl;
		logic [sample_bits-1:0] ampl_neg;
	} audio_cfg_t;

	typedef struct packed {
		logic lrclk;
		logic sclk;
		logic frame_load; // one cycle ahead of an lrclk change.
		logic bit_shift;  // one cycle ahead of an sclk fall.
	} i2s_timing_t;

	typedef struct packed {
		logic mclk;
		logic lrclk;
		logic sclk;
		logic sdata;
	} i2s_pins_t;

endpackage

`default_nettype wire

/* audio_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module audio_regs (
	input  wire logic                              CLK,
	input  wire logic                              rst_n,
	input  wire audio_pkg::reg_addr_e              addr,
	input  wire logic [audio_pkg::sample_bits-1:0] data_in,
	input  wire logic                              wr,
	output logic [audio_pkg::sample_bits-1:0]      data_out,
	output audio_pkg::audio_cfg_t                  cfg
);

	logic [audio_pkg::sample_bits-1:0] freq_q;
	logic [audio_pkg::sample_bits-1:0] ampl_q;
	logic [audio_pkg::sample_bits-1:0] ampl_neg_q;
	logic freq_we;
	logic ampl_we;

	assign freq_we = wr && (addr == audio_pkg::reg_freq);
	assign ampl_we = wr && (addr == audio_pkg::reg_ampl);

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			freq_q <= '0;
		end else if (freq_we) begin
			freq_q <= data_in;
		end
	end

	// the negated copy spares the serializer an adder.
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			ampl_q <= '0;
			ampl_neg_q <= '0;
		end else if (ampl_we) begin
			ampl_q <= data_in;
			ampl_neg_q <= -data_in; // two's complement.
		end
	end

	always_comb begin
		case (addr)
			audio_pkg::reg_freq: data_out = freq_q;
			audio_pkg::reg_ampl: data_out = ampl_q;
			default:             data_out = '0; // unmapped reads as zero.
		endcase
	end

	assign cfg.freq = freq_q;
	assign cfg.ampl = ampl_q;
	assign cfg.ampl_neg = ampl_neg_q;

endmodule

`default_nettype wire

/* i2s_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module i2s_clock_gen (
	input  wire logic              CLK,
	input  wire logic              rst_n,
	output audio_pkg::i2s_timing_t timing
);

	logic [audio_pkg::sclk_div_bits-1:0] sclk_cnt;
	logic [audio_pkg::lrclk_div_bits-1:0] lrclk_cnt;
	logic sclk_q;
	logic lrclk_q;
	logic frame_load_q;
	logic bit_shift_q;
	logic sclk_next;
	logic lrclk_next;
	logic frame_load_next;
	logic bit_shift_next;

	always_comb begin
		sclk_next = sclk_q;
		lrclk_next = lrclk_q;
		if (sclk_cnt == '0) begin
			sclk_next = ~sclk_q;
		end
		if (lrclk_cnt == '0) begin
			lrclk_next = ~lrclk_q;
		end
		// the strobe is registered, so it is armed on the last count.
		frame_load_next = (lrclk_cnt == '1);
		bit_shift_next = (sclk_cnt == '1) && sclk_q; // sclk high, so next toggle falls.
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			sclk_cnt <= '0;
			lrclk_cnt <= '0;
			sclk_q <= 1'b0;
			lrclk_q <= 1'b0;
			frame_load_q <= 1'b0;
			bit_shift_q <= 1'b0;
		end else begin
			sclk_cnt <= sclk_cnt + 1'b1;
			lrclk_cnt <= lrclk_cnt + 1'b1;
			sclk_q <= sclk_next;
			lrclk_q <= lrclk_next;
			frame_load_q <= frame_load_next;
			bit_shift_q <= bit_shift_next;
		end
	end

	assign timing.lrclk = lrclk_q;
	assign timing.sclk = sclk_q;
	assign timing.frame_load = frame_load_q;
	assign timing.bit_shift = bit_shift_q;

endmodule

`default_nettype wire

/* square_wave_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module square_wave_gen (
	input  wire logic                              CLK,
	input  wire logic                              rst_n,
	input  wire logic [audio_pkg::sample_bits-1:0] freq,
	output logic                                   level
);

	logic [audio_pkg::phase_bits-1:0] phase_acc;
	logic [audio_pkg::phase_bits-1:0] phase_next;
	logic [audio_pkg::phase_bits-1:0] freq_ext;
	logic level_next;
	logic wrap;

	assign freq_ext = {{(audio_pkg::phase_bits - audio_pkg::sample_bits){1'b0}}, freq};

	// above the limit the count restarts rather than adding once more.
	assign wrap = (phase_acc > audio_pkg::phase_limit);

	always_comb begin
		phase_next = phase_acc + freq_ext; // modulo 2**24.
		level_next = level;
		if (wrap) begin
			phase_next = '0;
			level_next = ~level;
		end
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			phase_acc <= '0;
			level <= 1'b0;
		end else begin
			phase_acc <= phase_next;
			level <= level_next;
		end
	end

endmodule

`default_nettype wire

/* i2s_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module i2s_serializer (
	input  wire logic                   CLK,
	input  wire logic                   rst_n,
	input  wire audio_pkg::i2s_timing_t timing,
	input  wire logic                   level,
	input  wire audio_pkg::audio_cfg_t  cfg,
	output logic                        sdata
);

	logic [audio_pkg::frame_bits-1:0] shift_q;
	logic [audio_pkg::frame_bits-1:0] shift_next;
	logic [audio_pkg::frame_bits-1:0] slot;
	logic [audio_pkg::sample_bits-1:0] word;

	// high half of the square wave goes out negated.
	assign word = level ? cfg.ampl_neg : cfg.ampl;

	always_comb begin
		slot = '0;
		slot[audio_pkg::word_msb:audio_pkg::word_lsb] = word;
	end

	always_comb begin
		shift_next = shift_q;
		if (timing.frame_load) begin
			shift_next = slot; // load wins over a shift.
		end else if (timing.bit_shift) begin
			shift_next = {shift_q[audio_pkg::frame_bits-2:0], 1'b0};
		end
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			shift_q <= '0;
		end else begin
			shift_q <= shift_next;
		end
	end

	assign sdata = shift_q[audio_pkg::frame_bits-1]; // msb first.

endmodule

`default_nettype wire

/* audio.sv */
`timescale 1ns/1ps
`default_nettype none

module audio (
	input  wire logic                              CLK,
	input  wire logic                              rst_n,
	input  wire logic [audio_pkg::addr_bits-1:0]   addr,
	input  wire logic [audio_pkg::sample_bits-1:0] data_in,
	input  wire logic                              wr,
	output logic [audio_pkg::sample_bits-1:0]      data_out,
	output audio_pkg::i2s_pins_t                   pins
);

	audio_pkg::audio_cfg_t cfg;
	audio_pkg::i2s_timing_t timing;
	logic level;
	logic sdata;

	audio_regs u_regs (
		.CLK      (CLK),
		.rst_n    (rst_n),
		.addr     (audio_pkg::reg_addr_e'(addr)),
		.data_in  (data_in),
		.wr       (wr),
		.data_out (data_out),
		.cfg      (cfg)
	);

	i2s_clock_gen u_clock_gen (
		.CLK    (CLK),
		.rst_n  (rst_n),
		.timing (timing)
	);

	square_wave_gen u_square (
		.CLK   (CLK),
		.rst_n (rst_n),
		.freq  (cfg.freq),
		.level (level)
	);

	i2s_serializer u_serializer (
		.CLK    (CLK),
		.rst_n  (rst_n),
		.timing (timing),
		.level  (level),
		.cfg    (cfg),
		.sdata  (sdata)
	);

	// master clock is the system clock itself.
	assign pins.mclk = CLK;
	assign pins.lrclk = timing.lrclk;
	assign pins.sclk = timing.sclk;
	assign pins.sdata = sdata;

endmodule

`default_nettype wire

/* tb_audio.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_audio;

	localparam int half_clks = 256; // lrclk half period in CLK.
	localparam int sclk_clks = 8;
	localparam int reset_frames = 2;
	localparam int steady_frames = 2;
	localparam int reg_frames = 1;
	localparam int tone_count = 4;
	localparam int tone_frames = 3;
	localparam int latency_frames = 3;
	localparam int total_frames = reset_frames + steady_frames + reg_frames
		+ tone_count * tone_frames + latency_frames + 3;
	localparam int margin_clks = 2048;

	logic CLK;
	logic rst_n;
	logic [audio_pkg::addr_bits-1:0] addr;
	logic [audio_pkg::sample_bits-1:0] data_in;
	logic wr;
	logic [audio_pkg::sample_bits-1:0] data_out;
	audio_pkg::i2s_pins_t pins;

	string test_name;
	logic [31:0] rng;
	logic [15:0] freq_shadow;
	logic [15:0] ampl_shadow;

	// reference model state.
	logic [audio_pkg::phase_bits-1:0] m_acc;
	logic m_level;
	logic [15:0] m_freq;
	logic [15:0] m_ampl;
	int m_edge;
	logic [15:0] exp_q[$];
	string name_q[$];

	// decoder state.
	logic prev_sclk;
	logic prev_lrclk;
	logic prev_sdata;
	int edge_idx;
	int cyc_since_lr;
	int cyc_since_sclk;
	bit lr_seen;
	bit sclk_seen;
	logic [15:0] rx_word;
	logic [15:0] act_q[$];

	logic [15:0] got_word;
	logic [15:0] want_word;
	string want_name;
	int words_checked;

	audio dut (
		.CLK      (CLK),
		.rst_n    (rst_n),
		.addr     (addr),
		.data_in  (data_in),
		.wr       (wr),
		.data_out (data_out),
		.pins     (pins)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// one CLK of the tone accumulator, returned as {level, count}.
	function automatic logic [audio_pkg::phase_bits:0] phase_step(
		input logic level,
		input logic [audio_pkg::phase_bits-1:0] acc,
		input logic [15:0] freq
	);
		if (acc > audio_pkg::phase_limit) begin
			return {~level, 24'h0};
		end
		return {level, acc + {8'h0, freq}};
	endfunction

	function automatic logic [15:0] expected_word(input logic level, input logic [15:0] ampl);
		if (level) begin
			return ~ampl + 16'd1; // high level sends the negated amplitude.
		end
		return ampl;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected) begin
			abort_run($sformatf("mismatch %s expected %0h actual %0h", name, expected, actual));
		end
	endtask

	task automatic next_rand(output logic [15:0] value);
		rng = lcg_next(rng);
		value = rng[31:16];
	endtask

	task automatic write_reg(input logic [3:0] a, input logic [15:0] d);
		@(posedge CLK);
		#2;
		addr = a;
		data_in = d;
		wr = 1'b1;
		@(posedge CLK);
		#2;
		wr = 1'b0;
		if (a == audio_pkg::reg_freq) begin
			freq_shadow = d;
		end else if (a == audio_pkg::reg_ampl) begin
			ampl_shadow = d;
		end
	endtask

	task automatic read_check(input string name, input logic [3:0] a, input logic [15:0] expected);
		@(posedge CLK);
		#2;
		addr = a;
		@(negedge CLK);
		check(name, 32'(expected), 32'(data_out));
	endtask

	task automatic wait_halves(input int n);
		int seen;
		logic last;
		seen = 0;
		last = pins.lrclk;
		while (seen < n) begin
			@(negedge CLK);
			if (pins.lrclk !== last) begin
				seen++;
				last = pins.lrclk;
			end
		end
	endtask

	// steps the model every CLK and queues the word due at each slot load.
	always @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			m_acc = '0;
			m_level = 1'b0;
			m_freq = 16'h0;
			m_ampl = 16'h0;
			m_edge = 0;
		end else begin
			m_edge = m_edge + 1;
			if (m_edge == 1) begin
				exp_q.push_back(16'h0); // nothing loaded before the first lrclk change.
				name_q.push_back(test_name);
			end else if ((m_edge - 1) % half_clks == 0) begin
				exp_q.push_back(expected_word(m_level, m_ampl));
				name_q.push_back(test_name);
			end
			{m_level, m_acc} = phase_step(m_level, m_acc, m_freq);
			if (wr && addr == audio_pkg::reg_freq) begin
				m_freq = data_in;
			end
			if (wr && addr == audio_pkg::reg_ampl) begin
				m_ampl = data_in;
			end
		end
	end

	// pins are sampled mid-cycle, so the previous sample is the value before an edge.
	always @(negedge CLK) begin
		if (!rst_n) begin
			check("reset lrclk", 0, 32'(pins.lrclk));
			check("reset sclk", 0, 32'(pins.sclk));
			check("reset sdata", 0, 32'(pins.sdata));
			check("reset data_out", 0, 32'(data_out));
			prev_sclk = 1'b0;
			prev_lrclk = 1'b0;
			prev_sdata = 1'b0;
			edge_idx = 0;
			cyc_since_lr = 0;
			cyc_since_sclk = 0;
			lr_seen = 1'b0;
			sclk_seen = 1'b0;
			rx_word = 16'h0;
		end else begin
			cyc_since_lr++;
			cyc_since_sclk++;
			if (pins.lrclk !== prev_lrclk) begin
				check("lrclk on sclk rise", 1, 32'(pins.sclk && !prev_sclk));
				if (lr_seen) begin
					check("lrclk half period", 32'(half_clks), cyc_since_lr);
					check("sclk rises per half", 31, edge_idx); // edges 0 to 31.
					act_q.push_back(rx_word);
				end
				lr_seen = 1'b1;
				cyc_since_lr = 0;
				edge_idx = 0;
				rx_word = 16'h0;
			end else if (pins.sclk && !prev_sclk) begin
				edge_idx++;
				if (edge_idx <= 16) begin
					rx_word = {rx_word[14:0], prev_sdata};
				end else begin
					check("slot tail zero", 0, 32'(prev_sdata));
				end
			end
			if (pins.sclk && !prev_sclk) begin
				if (sclk_seen) begin
					check("sclk period", 32'(sclk_clks), cyc_since_sclk);
				end
				sclk_seen = 1'b1;
				cyc_since_sclk = 0;
			end
			prev_sclk = pins.sclk;
			prev_lrclk = pins.lrclk;
			prev_sdata = pins.sdata;
		end
	end

	always @(posedge CLK) begin
		while (act_q.size() > 0) begin
			if (exp_q.size() == 0) begin
				abort_run("decoded a half-frame that the model never loaded");
			end else begin
				got_word = act_q.pop_front();
				want_word = exp_q.pop_front();
				want_name = name_q.pop_front();
				check(want_name, 32'(want_word), 32'(got_word));
				words_checked++;
			end
		end
	end

	always @(CLK) begin
		#1;
		check("mclk", 32'(CLK), 32'(pins.mclk));
	end

	initial begin
		repeat (total_frames * 2 * half_clks + margin_clks) @(posedge CLK);
		abort_run($sformatf("timeout, run did not end within %0d frames", total_frames));
	end

	initial begin
		logic [15:0] value;
		rst_n = 1'b0;
		addr = '0;
		data_in = '0;
		wr = 1'b0;
		rng = 32'h1f2d;
		freq_shadow = 16'h0;
		ampl_shadow = 16'h0;
		words_checked = 0;
		test_name = "reset";
		repeat (10) @(posedge CLK);
		#2;
		rst_n = 1'b1;
		@(negedge CLK);
		check("post reset lrclk", 0, 32'(pins.lrclk));
		check("post reset sclk", 0, 32'(pins.sclk));
		check("post reset sdata", 0, 32'(pins.sdata));
		check("post reset data_out", 0, 32'(data_out));
		wait_halves(2 * reset_frames);

		test_name = "steady tone";
		next_rand(value);
		write_reg(audio_pkg::reg_ampl, value);
		read_check("steady ampl", audio_pkg::reg_ampl, ampl_shadow);
		wait_halves(2 * steady_frames);

		test_name = "registers";
		for (int i = 0; i < 8; i++) begin
			next_rand(value);
			if (value[0]) begin
				write_reg(audio_pkg::reg_freq, value);
				read_check("freq readback", audio_pkg::reg_freq, freq_shadow);
			end else begin
				write_reg(audio_pkg::reg_ampl, value);
				read_check("ampl readback", audio_pkg::reg_ampl, ampl_shadow);
			end
		end
		for (int a = 2; a < 16; a++) begin
			next_rand(value);
			write_reg(4'(a), value);
			read_check("unmapped read", 4'(a), 16'h0);
		end
		read_check("freq kept", audio_pkg::reg_freq, freq_shadow);
		read_check("ampl kept", audio_pkg::reg_ampl, ampl_shadow);

		for (int t = 0; t < tone_count; t++) begin
			test_name = $sformatf("square wave %0d", t);
			next_rand(value);
			write_reg(audio_pkg::reg_freq, 16'h4000 | (value & 16'h3fff)); // toggles every 1 to 2 halves.
			next_rand(value);
			write_reg(audio_pkg::reg_ampl, value);
			wait_halves(2 * tone_frames);
		end

		test_name = "update latency";
		write_reg(audio_pkg::reg_freq, 16'h0);
		wait_halves(1);
		for (int k = 0; k < latency_frames; k++) begin
			wait_halves(1);
			repeat (half_clks / 2) @(posedge CLK);
			next_rand(value);
			write_reg(audio_pkg::reg_ampl, value);
		end

		test_name = "drain";
		wait_halves(2);
		@(posedge CLK);
		#1;
		// only the half-frame still on the pins stays queued.
		if (words_checked > 0 && exp_q.size() == 1) begin
			$display("Simulation passed");
			$finish;
		end else begin
			abort_run("half-frames were left unchecked at the end");
		end
	end

endmodule

`default_nettype wire

/* src.f */
audio_pkg.sv
audio_regs.sv
i2s_clock_gen.sv
square_wave_gen.sv
i2s_serializer.sv
audio.sv
tb_audio.sv

/* Makefile */
TOP := tb_audio

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing -f src.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
